//--- build.f
design/acq_record_pkg.sv
design/acq_ctrl_pkg.sv
design/acq_ctrl_if.sv
design/acq_input_sync.sv
design/acq_control.sv
design/circ_buf_reader.sv
design/record_builder.sv
design/acq_top.sv
verif/acq_tb.sv

//--- design/acq_control.sv
`default_nettype none

module acq_control #(
    parameter int BUF_ADDR_W  = 12,
    parameter int BURST_CNT_W = 8
) (
    input  wire logic                   clk,
    input  wire logic                   adc_acq_full_reset,
    input  wire logic                   armed,
    input  wire logic                   trig_pulse,
    input  wire logic                   trig_level,
    input  wire logic                   wr_done_sync,
    input  wire logic [BURST_CNT_W-1:0] burst_count,
    input  wire logic                   trig_addr_valid,
    output logic                        trig_addr_ready,
    output logic                        acq_done,
    output logic                        acq_busy,
    acq_ctrl_if.control                 ctrl
);

    localparam int WIDX_W = $clog2(acq_record_pkg::WORDS_PER_BURST);

    acq_ctrl_pkg::acq_state_t state;
    acq_ctrl_pkg::acq_state_t next_state;
    logic [BURST_CNT_W-1:0]   bursts_left;
    logic [WIDX_W-1:0]        word_cnt;
    logic                     push_done;
    logic                     last_word;

    // a push counts only when the builder takes it
    assign push_done = ctrl.rec_push & ctrl.rec_ready;
    assign last_word = (word_cnt == WIDX_W'(acq_record_pkg::WORDS_PER_BURST - 1));

    always_comb begin
        next_state = state;
        case (state)
            acq_ctrl_pkg::IDLE: begin
                if (armed) next_state = acq_ctrl_pkg::WATCH_FOR_TRIG;
            end
            acq_ctrl_pkg::WATCH_FOR_TRIG: begin
                if (trig_pulse) next_state = acq_ctrl_pkg::FILL_HDR;
                else if (!armed) next_state = acq_ctrl_pkg::IDLE;
            end
            acq_ctrl_pkg::FILL_HDR: begin
                if (push_done) next_state = acq_ctrl_pkg::WFM_ADDR;
            end
            // pop the FWFT fifo as soon as an address shows up
            acq_ctrl_pkg::WFM_ADDR: begin
                if (trig_addr_valid) next_state = acq_ctrl_pkg::WFM_HDR;
            end
            acq_ctrl_pkg::WFM_HDR: begin
                if (push_done) begin
                    // zero bursts goes straight to the checksum
                    if (bursts_left == '0) next_state = acq_ctrl_pkg::CHECKSUM;
                    else next_state = acq_ctrl_pkg::RUN_READ;
                end
            end
            acq_ctrl_pkg::RUN_READ: begin
                if (last_word) next_state = acq_ctrl_pkg::RUN_PUSH;
            end
            acq_ctrl_pkg::RUN_PUSH: begin
                if (push_done) begin
                    if (bursts_left == '0) next_state = acq_ctrl_pkg::CHECKSUM;
                    else next_state = acq_ctrl_pkg::RUN_READ;
                end
            end
            acq_ctrl_pkg::CHECKSUM: begin
                if (push_done) next_state = acq_ctrl_pkg::DDR3_WAIT;
            end
            acq_ctrl_pkg::DDR3_WAIT: begin
                if (wr_done_sync) next_state = acq_ctrl_pkg::DONE;
            end
            // hold until the trigger drops so a long trigger cannot refire
            acq_ctrl_pkg::DONE: begin
                if (!(armed && trig_level)) next_state = acq_ctrl_pkg::IDLE;
            end
            default: next_state = acq_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            state       <= acq_ctrl_pkg::IDLE;
            bursts_left <= '0;
            word_cnt    <= '0;
        end else begin
            state <= next_state;
            // burst count is sampled at the trigger
            if (state == acq_ctrl_pkg::WATCH_FOR_TRIG && trig_pulse) begin
                bursts_left <= burst_count;
            end else if (state == acq_ctrl_pkg::RUN_READ && last_word) begin
                bursts_left <= bursts_left - 1'b1;
            end
            // wraps back to 0 on the fourth read
            if (state == acq_ctrl_pkg::RUN_READ) word_cnt <= word_cnt + 1'b1;
        end
    end

    assign trig_addr_ready = (state == acq_ctrl_pkg::WFM_ADDR) & trig_addr_valid;
    assign ctrl.rd_start   = trig_addr_ready;
    assign ctrl.rd_word    = (state == acq_ctrl_pkg::RUN_READ);
    assign ctrl.cks_clear  = (state == acq_ctrl_pkg::FILL_HDR);
    // data push waits for the reader to finish packing
    assign ctrl.rec_push   = (state == acq_ctrl_pkg::FILL_HDR)
                           | (state == acq_ctrl_pkg::WFM_HDR)
                           | (state == acq_ctrl_pkg::CHECKSUM)
                           | ((state == acq_ctrl_pkg::RUN_PUSH) & ctrl.burst_valid);

    always_comb begin
        case (state)
            acq_ctrl_pkg::WFM_HDR:  ctrl.rec_sel = acq_ctrl_pkg::SEL_WFM_HDR;
            acq_ctrl_pkg::RUN_PUSH: ctrl.rec_sel = acq_ctrl_pkg::SEL_DATA;
            acq_ctrl_pkg::CHECKSUM: ctrl.rec_sel = acq_ctrl_pkg::SEL_CKSUM;
            default:                ctrl.rec_sel = acq_ctrl_pkg::SEL_FILL_HDR;
        endcase
    end

    assign acq_done = (state == acq_ctrl_pkg::DONE);
    // busy from the trigger until the fill is reported done
    assign acq_busy = (state != acq_ctrl_pkg::IDLE) & (state != acq_ctrl_pkg::WATCH_FOR_TRIG);

    // the reader flags the burst complete two cycles after its fourth read
    assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        $past(ctrl.rd_word && last_word, 2) |-> ctrl.burst_valid);

    // a fill never reads more words than the circular buffer holds
    assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        state == acq_ctrl_pkg::FILL_HDR |->
            int'(bursts_left) * acq_record_pkg::WORDS_PER_BURST <= (1 << BUF_ADDR_W));

endmodule

`default_nettype wire

//--- design/acq_ctrl_if.sv
`default_nettype none

// control strobes between sequencer, buffer reader and record builder
interface acq_ctrl_if;

    // reader side
    logic rd_start;
    logic rd_word;
    logic burst_valid;

    // builder side, valid/ready push
    logic                   rec_push;
    logic                   rec_ready;
    acq_ctrl_pkg::rec_sel_t rec_sel;
    logic                   cks_clear;

    modport control (
        output rd_start, rd_word, rec_push, rec_sel, cks_clear,
        input  burst_valid, rec_ready
    );

    modport reader (
        input  rd_start, rd_word,
        output burst_valid
    );

    modport builder (
        input  rec_push, rec_sel, cks_clear,
        output rec_ready
    );

endinterface

`default_nettype wire

//--- design/acq_ctrl_pkg.sv
`default_nettype none

package acq_ctrl_pkg;

    // acquisition sequencer states
    typedef enum logic [3:0] {
        IDLE,
        WATCH_FOR_TRIG,
        FILL_HDR,
        WFM_ADDR,
        WFM_HDR,
        RUN_READ,
        RUN_PUSH,
        CHECKSUM,
        DDR3_WAIT,
        DONE
    } acq_state_t;

    // which word the record builder forms on a push
    typedef enum logic [1:0] {
        SEL_FILL_HDR,
        SEL_WFM_HDR,
        SEL_DATA,
        SEL_CKSUM
    } rec_sel_t;

endpackage

`default_nettype wire

//--- design/acq_input_sync.sv
`default_nettype none

module acq_input_sync #(
    parameter int SYNC_STAGES = 4
) (
    input  wire logic       clk,
    input  wire logic       adc_acq_full_reset,
    input  wire logic       acq_enable0,
    input  wire logic       acq_enable1,
    input  wire logic       acq_trig,
    input  wire logic       ddr3_wr_done,
    output logic            armed,
    output logic [1:0]      fill_type,
    output logic            trig_pulse,
    output logic            trig_level,
    output logic            wr_done_sync
);

    // shift chains, bit 0 is the first flop after the pin
    logic [SYNC_STAGES-1:0] en0_sr;
    logic [SYNC_STAGES-1:0] en1_sr;
    // one extra trigger flop gives the previous level for edge detect
    logic [SYNC_STAGES:0]   trig_sr;
    logic [1:0]             done_sr;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            en0_sr     <= '0;
            en1_sr     <= '0;
            trig_sr    <= '0;
            done_sr    <= '0;
            trig_pulse <= 1'b0;
        end else begin
            en0_sr     <= {en0_sr[SYNC_STAGES-2:0], acq_enable0};
            en1_sr     <= {en1_sr[SYNC_STAGES-2:0], acq_enable1};
            trig_sr    <= {trig_sr[SYNC_STAGES-1:0], acq_trig};
            done_sr    <= {done_sr[0], ddr3_wr_done};
            // rising edge seen at the last stage, passed only while armed
            trig_pulse <= trig_sr[SYNC_STAGES-1] & ~trig_sr[SYNC_STAGES] & armed;
        end
    end

    // either enable set means we accept triggers
    assign armed        = en0_sr[SYNC_STAGES-1] | en1_sr[SYNC_STAGES-1];
    // enable pair doubles as the fill type
    assign fill_type    = {en1_sr[SYNC_STAGES-1], en0_sr[SYNC_STAGES-1]};
    assign trig_level   = trig_sr[SYNC_STAGES-1];
    assign wr_done_sync = done_sr[1];

endmodule

`default_nettype wire

//--- design/acq_record_pkg.sv
`default_nettype none

package acq_record_pkg;

    // record stream word and buffer sample word
    localparam int REC_W = 128;
    localparam int WORD_W = 32;
    // one data burst carries four consecutive buffer words
    localparam int WORDS_PER_BURST = 4;

    // tag in the top byte of every header word
    // data words carry no tag, TAG_DATA only names that view
    typedef enum logic [7:0] {
        TAG_DATA  = 8'h00,
        TAG_FILL  = 8'hF1,
        TAG_WFM   = 8'hA5,
        TAG_CKSUM = 8'hC5
    } rec_tag_t;

    // header layout, msb first
    typedef struct packed {
        rec_tag_t    tag;
        logic [23:0] fill_number;
        logic [31:0] field_a;
        logic [31:0] field_b;
        logic [31:0] field_c;
    } rec_hdr_t;

    // one record word seen as header or as a burst of samples
    // burst word 0 sits in the low 32 bits
    typedef union packed {
        rec_hdr_t                                 hdr;
        logic [WORDS_PER_BURST-1:0][WORD_W-1:0] burst;
    } rec_word_u;

    // running checksum, plain 32-bit sum of all data words of a fill
    function automatic logic [WORD_W-1:0] cksum_next(
        input logic [WORD_W-1:0]                      acc,
        input logic [WORDS_PER_BURST-1:0][WORD_W-1:0] words
    );
        logic [WORD_W-1:0] sum;
        sum = acc;
        for (int i = 0; i < WORDS_PER_BURST; i++) begin
            sum = sum + words[i];
        end
        return sum;
    endfunction

endpackage

`default_nettype wire

//--- design/acq_top.sv
`default_nettype none

module acq_top #(
    parameter int BUF_ADDR_W  = 12,
    parameter int BURST_CNT_W = 8,
    parameter int SYNC_STAGES = 4
) (
    input  wire logic                                clk,
    input  wire logic                                adc_acq_full_reset,
    input  wire logic                                acq_enable0,
    input  wire logic                                acq_enable1,
    input  wire logic                                acq_trig,
    input  wire logic                                ddr3_wr_done,
    input  wire logic [BURST_CNT_W-1:0]              burst_count,
    input  wire logic [BUF_ADDR_W-1:0]               trig_addr,
    input  wire logic                                trig_addr_valid,
    input  wire logic [acq_record_pkg::WORD_W-1:0]   buf_rd_data,
    input  wire logic                                rec_ready_in,
    output logic                                     trig_addr_ready,
    output logic                                     buf_rd_en,
    output logic [BUF_ADDR_W-1:0]                    buf_rd_addr,
    output logic [acq_record_pkg::REC_W-1:0]         rec_data,
    output logic                                     rec_valid,
    output logic                                     acq_done,
    output logic                                     acq_busy
);

    logic                              armed;
    logic [1:0]                        fill_type;
    logic                              trig_pulse;
    logic                              trig_level;
    logic                              wr_done_sync;
    logic [BUF_ADDR_W-1:0]             wfm_addr;
    logic [acq_record_pkg::WORD_W-1:0] wfm_addr_ext;
    logic [acq_record_pkg::WORDS_PER_BURST-1:0][acq_record_pkg::WORD_W-1:0] burst_data;
    // fill counter, observed from the testbench
    logic [23:0]                       fill_number;

    acq_ctrl_if ctrl_if ();

    // header field is a full word, address is zero extended
    assign wfm_addr_ext = {{(acq_record_pkg::WORD_W - BUF_ADDR_W){1'b0}}, wfm_addr};

    acq_input_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_sync (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .acq_enable0        (acq_enable0),
        .acq_enable1        (acq_enable1),
        .acq_trig           (acq_trig),
        .ddr3_wr_done       (ddr3_wr_done),
        .armed              (armed),
        .fill_type          (fill_type),
        .trig_pulse         (trig_pulse),
        .trig_level         (trig_level),
        .wr_done_sync       (wr_done_sync)
    );

    acq_control #(
        .BUF_ADDR_W  (BUF_ADDR_W),
        .BURST_CNT_W (BURST_CNT_W)
    ) u_control (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .armed              (armed),
        .trig_pulse         (trig_pulse),
        .trig_level         (trig_level),
        .wr_done_sync       (wr_done_sync),
        .burst_count        (burst_count),
        .trig_addr_valid    (trig_addr_valid),
        .trig_addr_ready    (trig_addr_ready),
        .acq_done           (acq_done),
        .acq_busy           (acq_busy),
        .ctrl               (ctrl_if)
    );

    circ_buf_reader #(
        .BUF_ADDR_W (BUF_ADDR_W)
    ) u_reader (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .trig_addr          (trig_addr),
        .buf_rd_data        (buf_rd_data),
        .buf_rd_en          (buf_rd_en),
        .buf_rd_addr        (buf_rd_addr),
        .wfm_addr           (wfm_addr),
        .burst_data         (burst_data),
        .ctrl               (ctrl_if)
    );

    record_builder #(
        .BURST_CNT_W (BURST_CNT_W)
    ) u_builder (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .fill_type          (fill_type),
        .burst_count        (burst_count),
        .wfm_addr           (wfm_addr_ext),
        .burst_data         (burst_data),
        .rec_ready_in       (rec_ready_in),
        .rec_data           (rec_data),
        .rec_valid          (rec_valid),
        .fill_number        (fill_number),
        .ctrl               (ctrl_if)
    );

endmodule

`default_nettype wire

//--- design/circ_buf_reader.sv
`default_nettype none

module circ_buf_reader #(
    parameter int BUF_ADDR_W = 12
) (
    input  wire logic                                    clk,
    input  wire logic                                    adc_acq_full_reset,
    input  wire logic [BUF_ADDR_W-1:0]                   trig_addr,
    input  wire logic [acq_record_pkg::WORD_W-1:0]       buf_rd_data,
    output logic                                         buf_rd_en,
    output logic [BUF_ADDR_W-1:0]                        buf_rd_addr,
    output logic [BUF_ADDR_W-1:0]                        wfm_addr,
    output logic [acq_record_pkg::WORDS_PER_BURST-1:0]
                 [acq_record_pkg::WORD_W-1:0]            burst_data,
    acq_ctrl_if.reader                                   ctrl
);

    localparam int WIDX_W = $clog2(acq_record_pkg::WORDS_PER_BURST);

    logic [BUF_ADDR_W-1:0] rd_addr;
    // read data returns one cycle after the request
    logic                  lat_q;
    logic [WIDX_W-1:0]     lat_idx;

    // address counter wraps at the buffer size on its own
    always_ff @(posedge clk) begin
        if (ctrl.rd_start) begin
            rd_addr  <= trig_addr;
            wfm_addr <= trig_addr;
        end else if (ctrl.rd_word) begin
            rd_addr <= rd_addr + 1'b1;
        end
        if (lat_q) burst_data[lat_idx] <= buf_rd_data;
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            lat_q            <= 1'b0;
            lat_idx          <= '0;
            ctrl.burst_valid <= 1'b0;
        end else begin
            lat_q <= ctrl.rd_word;
            if (ctrl.rd_start) lat_idx <= '0;
            else if (lat_q) lat_idx <= lat_idx + 1'b1;
            // full once the last word of the burst lands
            if (ctrl.rd_start || ctrl.rd_word) begin
                ctrl.burst_valid <= 1'b0;
            end else if (lat_q && lat_idx == WIDX_W'(acq_record_pkg::WORDS_PER_BURST - 1)) begin
                ctrl.burst_valid <= 1'b1;
            end
        end
    end

    assign buf_rd_en   = ctrl.rd_word;
    assign buf_rd_addr = rd_addr;

    // a burst gets exactly four reads before it is handed on
    assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        ctrl.rd_word |->
            !(lat_q && lat_idx == WIDX_W'(acq_record_pkg::WORDS_PER_BURST - 1)));

endmodule

`default_nettype wire

//--- design/record_builder.sv
`default_nettype none

module record_builder #(
    parameter int BURST_CNT_W = 8
) (
    input  wire logic                                    clk,
    input  wire logic                                    adc_acq_full_reset,
    input  wire logic [1:0]                              fill_type,
    input  wire logic [BURST_CNT_W-1:0]                  burst_count,
    input  wire logic [acq_record_pkg::WORD_W-1:0]       wfm_addr,
    input  wire logic [acq_record_pkg::WORDS_PER_BURST-1:0]
                      [acq_record_pkg::WORD_W-1:0]       burst_data,
    input  wire logic                                    rec_ready_in,
    output logic [acq_record_pkg::REC_W-1:0]             rec_data,
    output logic                                         rec_valid,
    output logic [23:0]                                  fill_number,
    acq_ctrl_if.builder                                  ctrl
);

    acq_record_pkg::rec_word_u         next_word;
    logic [acq_record_pkg::WORD_W-1:0] cksum;
    logic [BURST_CNT_W-1:0]            data_bursts;
    logic                              push_ok;

    // free when empty or when the held word leaves this cycle
    assign ctrl.rec_ready = ~rec_valid | rec_ready_in;
    assign push_ok        = ctrl.rec_push & ctrl.rec_ready;

    // form the word the sequencer asked for
    always_comb begin
        next_word = '0;
        next_word.hdr.fill_number = fill_number;
        case (ctrl.rec_sel)
            acq_ctrl_pkg::SEL_FILL_HDR: begin
                next_word.hdr.tag     = acq_record_pkg::TAG_FILL;
                next_word.hdr.field_a = 32'(burst_count);
                next_word.hdr.field_b = 32'(fill_type);
            end
            acq_ctrl_pkg::SEL_WFM_HDR: begin
                next_word.hdr.tag     = acq_record_pkg::TAG_WFM;
                next_word.hdr.field_a = wfm_addr;
                next_word.hdr.field_b = 32'(burst_count);
            end
            // samples overwrite the whole word and carry no tag
            acq_ctrl_pkg::SEL_DATA: begin
                next_word.burst = burst_data;
            end
            default: begin
                next_word.hdr.tag     = acq_record_pkg::TAG_CKSUM;
                next_word.hdr.field_a = cksum;
                next_word.hdr.field_b = 32'(data_bursts);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (push_ok) rec_data <= next_word;
        // checksum and burst tally restart with every fill header
        if (ctrl.cks_clear) begin
            cksum       <= '0;
            data_bursts <= '0;
        end else if (push_ok && ctrl.rec_sel == acq_ctrl_pkg::SEL_DATA) begin
            cksum       <= acq_record_pkg::cksum_next(cksum, burst_data);
            data_bursts <= data_bursts + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            rec_valid   <= 1'b0;
            fill_number <= '0;
        end else begin
            if (push_ok) rec_valid <= 1'b1;
            else if (rec_ready_in) rec_valid <= 1'b0;
            // next fill gets the next number once its checksum is taken
            if (push_ok && ctrl.rec_sel == acq_ctrl_pkg::SEL_CKSUM) begin
                fill_number <= fill_number + 1'b1;
            end
        end
    end

    // a push that has to wait keeps its select
    assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        ctrl.rec_push && !ctrl.rec_ready |=> ctrl.rec_push && $stable(ctrl.rec_sel));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module acq_tb -o acq_sim
./obj_dir/acq_sim 2>&1 | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

//--- verif/acq_tb.sv
`default_nettype none

module acq_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [acq_record_pkg::REC_W-1:0] rec_q_t[$];

    localparam int BUF_WORDS  = 4096;
    localparam int WAIT_LIMIT = 4000;

    logic         clk;
    logic         adc_acq_full_reset;
    logic         acq_enable0;
    logic         acq_enable1;
    logic         acq_trig;
    logic         ddr3_wr_done;
    logic [7:0]   burst_count;
    logic [11:0]  trig_addr;
    logic         trig_addr_valid;
    logic [31:0]  buf_rd_data;
    logic         rec_ready_in;
    logic         trig_addr_ready;
    logic         buf_rd_en;
    logic [11:0]  buf_rd_addr;
    logic [127:0] rec_data;
    logic         rec_valid;
    logic         acq_done;
    logic         acq_busy;

    // circular sample buffer seen by the DUT
    logic [31:0]  buf_mem [BUF_WORDS];
    logic [31:0]  lcg_state;
    logic         rd_pend;
    logic [11:0]  rd_pend_addr;
    logic         backpressure;
    // trigger address fifo with its head shown on trig_addr
    logic [11:0]  trig_q[$];
    logic [127:0] exp_q[$];
    string        test_name;
    int           fills_done;
    int           exp_total;
    int           words_seen;
    int           mismatches;
    int           failures;
    acq_record_pkg::rec_word_u got_w;
    acq_record_pkg::rec_word_u exp_w;

    acq_top UUT (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .acq_enable0        (acq_enable0),
        .acq_enable1        (acq_enable1),
        .acq_trig           (acq_trig),
        .ddr3_wr_done       (ddr3_wr_done),
        .burst_count        (burst_count),
        .trig_addr          (trig_addr),
        .trig_addr_valid    (trig_addr_valid),
        .buf_rd_data        (buf_rd_data),
        .rec_ready_in       (rec_ready_in),
        .trig_addr_ready    (trig_addr_ready),
        .buf_rd_en          (buf_rd_en),
        .buf_rd_addr        (buf_rd_addr),
        .rec_data           (rec_data),
        .rec_valid          (rec_valid),
        .acq_done           (acq_done),
        .acq_busy           (acq_busy)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // whole record of one fill built straight from the record format
    function automatic rec_q_t expected_fill(input int fill_no, input logic [1:0] ftype,
                                             input logic [11:0] addr, input logic [7:0] bc);
        rec_q_t                    words;
        acq_record_pkg::rec_word_u w;
        logic [31:0]               sum;
        logic [11:0]               a;
        sum = '0;
        a = addr;
        w = '0;
        w.hdr.tag         = acq_record_pkg::TAG_FILL;
        w.hdr.fill_number = 24'(fill_no);
        w.hdr.field_a     = 32'(bc);
        w.hdr.field_b     = 32'(ftype);
        words.push_back(w);
        w.hdr.tag     = acq_record_pkg::TAG_WFM;
        w.hdr.field_a = 32'(addr);
        w.hdr.field_b = 32'(bc);
        words.push_back(w);
        for (int b = 0; b < int'(bc); b++) begin
            for (int k = 0; k < 4; k++) begin
                w.burst[k] = buf_mem[a];
                sum = sum + buf_mem[a];
                // 12-bit address wraps at the buffer end
                a = a + 12'd1;
            end
            words.push_back(w);
        end
        w = '0;
        w.hdr.tag         = acq_record_pkg::TAG_CKSUM;
        w.hdr.fill_number = 24'(fill_no);
        w.hdr.field_a     = sum;
        w.hdr.field_b     = 32'(bc);
        words.push_back(w);
        return words;
    endfunction

    // read port sees the request at a rising edge and answers one cycle later
    always @(posedge clk) begin
        rd_pend      <= buf_rd_en;
        rd_pend_addr <= buf_rd_addr;
        if (trig_addr_ready && trig_q.size() != 0) begin
            void'(trig_q.pop_front());
        end
    end

    always @(negedge clk) begin
        if (rd_pend) buf_rd_data <= buf_mem[rd_pend_addr];
        trig_addr_valid <= (trig_q.size() != 0);
        if (trig_q.size() != 0) trig_addr <= trig_q[0];
        lcg_state = lcg_next(lcg_state);
        rec_ready_in <= backpressure ? lcg_state[16] : 1'b1;
    end

    // compare every accepted output word against the expected stream
    always @(posedge clk) begin
        if (!adc_acq_full_reset && rec_valid && rec_ready_in) begin
            words_seen++;
            assert (exp_q.size() != 0) else begin
                failures++;
                $display("%s: output word %h arrived with none expected", test_name, rec_data);
            end
            if (exp_q.size() != 0) begin
                exp_w = exp_q.pop_front();
                got_w = rec_data;
                assert (got_w == exp_w) else begin
                    mismatches++;
                    $display("MISMATCH %s: expected %h actual %h", test_name, exp_w, got_w);
                    $display("  actual as header tag %h fill %0d, as burst word0 %h",
                             got_w.hdr.tag, got_w.hdr.fill_number, got_w.burst[0]);
                end
            end
        end
    end

    task automatic wait_for_record();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            failures++;
            $display("%s: timed out with %0d record words still missing", test_name,
                     exp_q.size());
        end
    endtask

    task automatic wait_for_done(input logic level);
        int n;
        n = 0;
        while (acq_done !== level && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (acq_done === level) else begin
            failures++;
            $display("%s: timed out waiting for acq_done to become %0b", test_name, level);
        end
    endtask

    task automatic run_fill(input string name, input logic [1:0] ftype,
                            input logic [11:0] addr, input logic [7:0] bc,
                            input logic hold_trig);
        rec_q_t words;
        test_name   = name;
        acq_enable0 = ftype[0];
        acq_enable1 = ftype[1];
        burst_count = bc;
        // enables need to pass the synchronizer before the trigger
        repeat (8) @(negedge clk);
        words = expected_fill(fills_done, ftype, addr, bc);
        exp_total += words.size();
        foreach (words[i]) exp_q.push_back(words[i]);
        trig_q.push_back(addr);
        acq_trig = 1'b1;
        wait_for_record();
        assert (acq_busy) else begin
            failures++;
            $display("%s: acq_busy low while the fill waits for write-done", name);
        end
        if (!hold_trig) acq_trig = 1'b0;
        // no write-done yet
        repeat (20) begin
            @(negedge clk);
            assert (!acq_done) else begin
                failures++;
                $display("%s: acq_done rose before ddr3_wr_done was driven", name);
            end
        end
        ddr3_wr_done = 1'b1;
        wait_for_done(1'b1);
        ddr3_wr_done = 1'b0;
        assert (trig_q.size() == 0) else begin
            failures++;
            $display("%s: trigger address was never taken from the fifo", name);
        end
        fills_done++;
        if (!hold_trig) wait_for_done(1'b0);
    endtask

    initial begin
        int          n;
        logic [11:0] rand_addr;
        adc_acq_full_reset = 1'b1;
        acq_enable0     = 1'b0;
        acq_enable1     = 1'b0;
        acq_trig        = 1'b0;
        ddr3_wr_done    = 1'b0;
        burst_count     = '0;
        trig_addr       = '0;
        trig_addr_valid = 1'b0;
        buf_rd_data     = '0;
        rec_ready_in    = 1'b1;
        backpressure    = 1'b0;
        rd_pend         = 1'b0;
        rd_pend_addr    = '0;
        test_name       = "reset";
        fills_done = 0;
        exp_total  = 0;
        words_seen = 0;
        mismatches = 0;
        failures   = 0;
        lcg_state  = 32'd53;
        for (int i = 0; i < BUF_WORDS; i++) begin
            lcg_state = lcg_next(lcg_state);
            buf_mem[i] = lcg_state;
        end
        rand_addr = lcg_state[27:16];
        repeat (10) @(negedge clk);
        adc_acq_full_reset = 1'b0;
        assert (!rec_valid && !trig_addr_ready && !buf_rd_en && !acq_done && !acq_busy
                && UUT.fill_number == 24'd0) else begin
            failures++;
            $display("outputs not in their reset state after reset");
        end

        // fill 0 with the trigger kept high afterwards
        run_fill("single_fill", 2'b01, 12'd100, 8'd3, 1'b1);
        n = words_seen;
        repeat (40) @(negedge clk);
        assert (acq_done && words_seen == n) else begin
            failures++;
            $display("held trigger started a second fill");
        end
        acq_trig = 1'b0;
        wait_for_done(1'b0);

        run_fill("wrap_fill", 2'b10, 12'd4094, 8'd3, 1'b0);
        backpressure = 1'b1;
        run_fill("backpressure_fill", 2'b11, rand_addr, 8'd5, 1'b0);
        backpressure = 1'b0;

        // with both enables low trigger edges must be ignored
        test_name   = "disabled_trigger";
        acq_enable0 = 1'b0;
        acq_enable1 = 1'b0;
        n = words_seen;
        repeat (10) @(negedge clk);
        repeat (3) begin
            acq_trig = 1'b1;
            repeat (10) @(negedge clk);
            acq_trig = 1'b0;
            repeat (10) @(negedge clk);
        end
        assert (words_seen == n && !acq_busy) else begin
            failures++;
            $display("trigger with both enables low started an acquisition");
        end

        run_fill("zero_burst", 2'b01, 12'd7, 8'd0, 1'b0);

        assert (words_seen == exp_total) else begin
            failures++;
            $display("saw %0d output words in total, %0d were expected", words_seen, exp_total);
        end
        $display("words checked %0d, mismatches %0d, other errors %0d",
                 words_seen, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
